/* logic/fe_buf_pkg.sv */
// ========================================
// shared types for the triple feature buffer
// ROW_GRP_NUM and BANK_NUM are fixed; the
// row address, depth and word width are
// module parameters set from fe_buf_top
// ========================================
`default_nettype none

package fe_buf_pkg;

    localparam int ROW_GRP_NUM = 4;                   // row-group sub-RAMs per bank
    localparam int BANK_NUM    = 3;
    localparam int GRP_SEL_W   = $clog2(ROW_GRP_NUM); // group field above the AXI row address

    // one-hot bank select, zero means no bank
    typedef logic [BANK_NUM-1:0] bank_mask_t;

    // per-group enable
    typedef logic [ROW_GRP_NUM-1:0] grp_mask_t;

    localparam bank_mask_t BANK_NONE = 3'b000;
    localparam bank_mask_t BANK_0    = 3'b001;
    localparam bank_mask_t BANK_1    = 3'b010;
    localparam bank_mask_t BANK_2    = 3'b100;

    // role states, the name reads scheduler / PU / AXI per bank
    typedef enum logic [2:0] {
        ST_A0       = 3'd0,  // load phase, only AXI active
        ST_S0_P1_A2 = 3'd1,
        ST_P0_S1_A2 = 3'd2,
        ST_P0_A1_S2 = 3'd3,
        ST_A0_P1_S2 = 3'd4,
        ST_S0_A1_P2 = 3'd5,
        ST_A0_S1_P2 = 3'd6
    } fe_state_t;

    // start control, other codes are ignored
    typedef enum logic [1:0] {
        STAT_IDLE  = 2'b00,
        STAT_START = 2'b11
    } stat_ctrl_t;

endpackage

`default_nettype wire

/* logic/bank_role_fsm.sv */
// ========================================
// role rotation across the three banks
// masks are registered from the state, so
// they trail a transition by one cycle
// in ST_A0 only the AXI mask is rewritten
// ========================================
`default_nettype none

module bank_role_fsm
    import fe_buf_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  stat_ctrl_t stat_ctrl,
    input  logic       layer_done,
    input  logic       tile_switch_r,
    output bank_mask_t axi_bank,
    output bank_mask_t pu_bank,
    output bank_mask_t sch_bank
);

    fe_state_t state_q;
    fe_state_t state_d;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= ST_A0;
        end else begin
            state_q <= state_d;
        end
    end

    // tile_switch_r low swaps PU and scheduler, high moves the AXI role
    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_A0: begin
                if (stat_ctrl == STAT_START) state_d = ST_S0_P1_A2;
            end
            ST_S0_P1_A2: begin
                if (layer_done) state_d = tile_switch_r ? ST_P0_A1_S2 : ST_P0_S1_A2;
            end
            ST_P0_S1_A2: begin
                if (layer_done) state_d = tile_switch_r ? ST_A0_P1_S2 : ST_S0_P1_A2;
            end
            ST_P0_A1_S2: begin
                if (layer_done) state_d = tile_switch_r ? ST_A0_S1_P2 : ST_S0_A1_P2;
            end
            ST_A0_P1_S2: begin
                if (layer_done) state_d = tile_switch_r ? ST_S0_A1_P2 : ST_A0_S1_P2;
            end
            ST_S0_A1_P2: begin
                if (layer_done) state_d = tile_switch_r ? ST_P0_S1_A2 : ST_P0_A1_S2;
            end
            ST_A0_S1_P2: begin
                if (layer_done) state_d = tile_switch_r ? ST_S0_P1_A2 : ST_A0_P1_S2;
            end
            default: state_d = ST_A0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            axi_bank <= BANK_NONE;
            pu_bank  <= BANK_NONE;
            sch_bank <= BANK_NONE;
        end else begin
            case (state_q)
                ST_A0: axi_bank <= BANK_0; // pu / sch hold
                ST_S0_P1_A2: begin
                    sch_bank <= BANK_0;
                    pu_bank  <= BANK_1;
                    axi_bank <= BANK_2;
                end
                ST_P0_S1_A2: begin
                    pu_bank  <= BANK_0;
                    sch_bank <= BANK_1;
                    axi_bank <= BANK_2;
                end
                ST_P0_A1_S2: begin
                    pu_bank  <= BANK_0;
                    axi_bank <= BANK_1;
                    sch_bank <= BANK_2;
                end
                ST_A0_P1_S2: begin
                    axi_bank <= BANK_0;
                    pu_bank  <= BANK_1;
                    sch_bank <= BANK_2;
                end
                ST_S0_A1_P2: begin
                    sch_bank <= BANK_0;
                    axi_bank <= BANK_1;
                    pu_bank  <= BANK_2;
                end
                ST_A0_S1_P2: begin
                    axi_bank <= BANK_0;
                    sch_bank <= BANK_1;
                    pu_bank  <= BANK_2;
                end
                default: begin
                    axi_bank <= BANK_NONE;
                    pu_bank  <= BANK_NONE;
                    sch_bank <= BANK_NONE;
                end
            endcase
        end
    end

    a_mask_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(axi_bank) && $onehot0(pu_bank) && $onehot0(sch_bank));

    // no two ports may own one bank once the rotation runs
    a_mask_disjoint: assert property (@(posedge clk) disable iff (!rst_n)
        (state_q != ST_A0) |->
            ((axi_bank & pu_bank) == BANK_NONE) && ((axi_bank & sch_bank) == BANK_NONE) &&
            ((pu_bank & sch_bank) == BANK_NONE));

    a_state_legal: assert property (@(posedge clk) disable iff (!rst_n)
        state_q inside {ST_A0, ST_S0_P1_A2, ST_P0_S1_A2, ST_P0_A1_S2,
                        ST_A0_P1_S2, ST_S0_A1_P2, ST_A0_S1_P2});

endmodule

`default_nettype wire

/* logic/bank_port_mux.sv */
// ========================================
// routes AXI, PU and scheduler onto banks
// PU wins writes and scheduler wins reads
// on the bank they own; AXI only reaches
// the bank its mask selects
// ========================================
`default_nettype none

module bank_port_mux
    import fe_buf_pkg::*;
#(
    parameter int ADDR_WIDTH = 5,
    parameter int DATA_WIDTH = 32
) (
    input  bank_mask_t                          axi_bank,
    input  bank_mask_t                          pu_bank,
    input  bank_mask_t                          sch_bank,
    input  logic [ADDR_WIDTH+GRP_SEL_W-1:0]     axi_waddr,
    input  logic                                axi_wen,
    input  logic [DATA_WIDTH-1:0]               axi_wdata,
    input  logic [ADDR_WIDTH+GRP_SEL_W-1:0]     axi_raddr,
    input  logic                                axi_ren,
    input  grp_mask_t                           pu_wen,
    input  logic [ADDR_WIDTH-1:0]               pu_waddr,
    input  logic [DATA_WIDTH-1:0]               pu_wdata   [ROW_GRP_NUM],
    input  grp_mask_t                           sch_ren,
    input  logic [ADDR_WIDTH-1:0]               sch_raddr  [ROW_GRP_NUM],
    output grp_mask_t                           bank_wen   [BANK_NUM],
    output logic [ADDR_WIDTH-1:0]               bank_waddr [BANK_NUM],
    output logic [DATA_WIDTH-1:0]               bank_wdata [BANK_NUM][ROW_GRP_NUM],
    output grp_mask_t                           bank_ren   [BANK_NUM],
    output logic [ADDR_WIDTH-1:0]               bank_raddr [BANK_NUM][ROW_GRP_NUM]
);

    localparam int AXI_AW = ADDR_WIDTH + GRP_SEL_W;

    grp_mask_t axi_wgrp;
    grp_mask_t axi_rgrp;

    // top address bits pick one sub-RAM
    assign axi_wgrp = axi_wen ? (grp_mask_t'(1) << axi_waddr[AXI_AW-1 -: GRP_SEL_W]) : '0;
    assign axi_rgrp = axi_ren ? (grp_mask_t'(1) << axi_raddr[AXI_AW-1 -: GRP_SEL_W]) : '0;

    // write side
    always_comb begin
        for (int b = 0; b < BANK_NUM; b++) begin
            if (pu_bank[b]) begin
                bank_wen[b]   = pu_wen;
                bank_waddr[b] = pu_waddr;
                for (int g = 0; g < ROW_GRP_NUM; g++) begin
                    bank_wdata[b][g] = pu_wdata[g];
                end
            end else begin
                bank_wen[b]   = axi_bank[b] ? axi_wgrp : '0; // unowned bank stays idle
                bank_waddr[b] = axi_waddr[ADDR_WIDTH-1:0];
                for (int g = 0; g < ROW_GRP_NUM; g++) begin
                    bank_wdata[b][g] = axi_wdata;
                end
            end
        end
    end

    // read side
    always_comb begin
        for (int b = 0; b < BANK_NUM; b++) begin
            if (sch_bank[b]) begin
                bank_ren[b] = sch_ren;
                for (int g = 0; g < ROW_GRP_NUM; g++) begin
                    bank_raddr[b][g] = sch_raddr[g];
                end
            end else begin
                bank_ren[b] = axi_bank[b] ? axi_rgrp : '0;
                for (int g = 0; g < ROW_GRP_NUM; g++) begin
                    bank_raddr[b][g] = axi_raddr[ADDR_WIDTH-1:0];
                end
            end
        end
    end

endmodule

`default_nettype wire

/* logic/feature_bank.sv */
// ========================================
// one bank, four simple dual-port sub-RAMs
// read data registered, one cycle latency
// same-row write and read returns old data
// no reset on the arrays or read registers
// ========================================
`default_nettype none

module feature_bank
    import fe_buf_pkg::*;
#(
    parameter int ADDR_WIDTH = 5,
    parameter int DEPTH      = 32,
    parameter int DATA_WIDTH = 32
) (
    input  logic                  clk,
    input  grp_mask_t             wen,
    input  logic [ADDR_WIDTH-1:0] waddr,
    input  logic [DATA_WIDTH-1:0] wdata [ROW_GRP_NUM],
    input  grp_mask_t             ren,
    input  logic [ADDR_WIDTH-1:0] raddr [ROW_GRP_NUM],
    output logic [DATA_WIDTH-1:0] rdata [ROW_GRP_NUM]
);

    for (genvar g = 0; g < ROW_GRP_NUM; g++) begin : g_grp
        logic [DATA_WIDTH-1:0] mem [DEPTH];
        logic [DATA_WIDTH-1:0] rd_q;

        always_ff @(posedge clk) begin
            if (wen[g]) begin
                mem[waddr] <= wdata[g];
            end
            if (ren[g]) begin
                rd_q <= mem[raddr[g]]; // holds until the next read
            end
        end

        assign rdata[g] = rd_q;

        a_waddr_range: assert property (@(posedge clk) wen[g] |-> (waddr < DEPTH));
        a_raddr_range: assert property (@(posedge clk) ren[g] |-> (raddr[g] < DEPTH));
    end

endmodule

`default_nettype wire

/* logic/read_return.sv */
// ========================================
// read return path
// bank and group are captured with the read
// strobe, so data stays tied to the bank
// that was read even if roles move on
// ========================================
`default_nettype none

module read_return
    import fe_buf_pkg::*;
#(
    parameter int ADDR_WIDTH = 5,
    parameter int DATA_WIDTH = 32
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  bank_mask_t                      axi_bank,
    input  bank_mask_t                      sch_bank,
    input  logic                            axi_ren,
    input  logic [ADDR_WIDTH+GRP_SEL_W-1:0] axi_raddr,
    input  grp_mask_t                       sch_ren,
    input  logic [DATA_WIDTH-1:0]           bank_rdata [BANK_NUM][ROW_GRP_NUM],
    output logic [DATA_WIDTH-1:0]           axi_rdata,
    output logic [DATA_WIDTH-1:0]           sch_rdata  [ROW_GRP_NUM]
);

    localparam int AXI_AW = ADDR_WIDTH + GRP_SEL_W;

    logic [GRP_SEL_W-1:0] axi_grp_q;
    bank_mask_t           axi_bank_q;
    bank_mask_t           sch_bank_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            axi_grp_q  <= '0;
            axi_bank_q <= BANK_NONE;
            sch_bank_q <= BANK_NONE;
        end else begin
            if (axi_ren) begin
                axi_grp_q  <= axi_raddr[AXI_AW-1 -: GRP_SEL_W];
                axi_bank_q <= axi_bank;
            end
            if (|sch_ren) begin
                sch_bank_q <= sch_bank;
            end
        end
    end

    always_comb begin
        axi_rdata = '0;
        for (int b = 0; b < BANK_NUM; b++) begin
            if (axi_bank_q[b]) axi_rdata = bank_rdata[b][axi_grp_q];
        end
    end

    // each group word comes from the same scheduler bank
    always_comb begin
        for (int g = 0; g < ROW_GRP_NUM; g++) begin
            sch_rdata[g] = '0;
            for (int b = 0; b < BANK_NUM; b++) begin
                if (sch_bank_q[b]) sch_rdata[g] = bank_rdata[b][g];
            end
        end
    end

endmodule

`default_nettype wire

/* logic/fe_buf_top.sv */
// ========================================
// triple feature buffer, top level
// AXI address is {group, row}, word wide
// fixed one-cycle read latency, no stall
// roles move two cycles after a start or
// layer_done strobe
// ========================================
`default_nettype none

module fe_buf_top
    import fe_buf_pkg::*;
#(
    parameter int ADDR_WIDTH = 5,
    parameter int DEPTH      = 32,
    parameter int DATA_WIDTH = 32
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            layer_done,
    input  logic                            tile_switch_r,
    input  stat_ctrl_t                      stat_ctrl,
    input  logic [ADDR_WIDTH+GRP_SEL_W-1:0] axi_waddr,
    input  logic                            axi_wen,
    input  logic [DATA_WIDTH-1:0]           axi_wdata,
    input  logic [ADDR_WIDTH+GRP_SEL_W-1:0] axi_raddr,
    input  logic                            axi_ren,
    output logic [DATA_WIDTH-1:0]           axi_rdata,
    input  grp_mask_t                       pu_wen,
    input  logic [ADDR_WIDTH-1:0]           pu_waddr,
    input  logic [DATA_WIDTH-1:0]           pu_wdata  [ROW_GRP_NUM],
    input  grp_mask_t                       sch_ren,
    input  logic [ADDR_WIDTH-1:0]           sch_raddr [ROW_GRP_NUM],
    output logic [DATA_WIDTH-1:0]           sch_rdata [ROW_GRP_NUM]
);

    wire bank_mask_t            axi_bank;
    wire bank_mask_t            pu_bank;
    wire bank_mask_t            sch_bank;
    wire grp_mask_t             bank_wen   [BANK_NUM];
    wire [ADDR_WIDTH-1:0]       bank_waddr [BANK_NUM];
    wire [DATA_WIDTH-1:0]       bank_wdata [BANK_NUM][ROW_GRP_NUM];
    wire grp_mask_t             bank_ren   [BANK_NUM];
    wire [ADDR_WIDTH-1:0]       bank_raddr [BANK_NUM][ROW_GRP_NUM];
    wire [DATA_WIDTH-1:0]       bank_rdata [BANK_NUM][ROW_GRP_NUM];

    bank_role_fsm u_fsm (
        .clk           (clk),
        .rst_n         (rst_n),
        .stat_ctrl     (stat_ctrl),
        .layer_done    (layer_done),
        .tile_switch_r (tile_switch_r),
        .axi_bank      (axi_bank),
        .pu_bank       (pu_bank),
        .sch_bank      (sch_bank)
    );

    bank_port_mux #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .DATA_WIDTH (DATA_WIDTH)
    ) u_mux (
        .axi_bank   (axi_bank),
        .pu_bank    (pu_bank),
        .sch_bank   (sch_bank),
        .axi_waddr  (axi_waddr),
        .axi_wen    (axi_wen),
        .axi_wdata  (axi_wdata),
        .axi_raddr  (axi_raddr),
        .axi_ren    (axi_ren),
        .pu_wen     (pu_wen),
        .pu_waddr   (pu_waddr),
        .pu_wdata   (pu_wdata),
        .sch_ren    (sch_ren),
        .sch_raddr  (sch_raddr),
        .bank_wen   (bank_wen),
        .bank_waddr (bank_waddr),
        .bank_wdata (bank_wdata),
        .bank_ren   (bank_ren),
        .bank_raddr (bank_raddr)
    );

    feature_bank #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .DEPTH      (DEPTH),
        .DATA_WIDTH (DATA_WIDTH)
    ) u_bank0 (
        .clk   (clk),
        .wen   (bank_wen[0]),
        .waddr (bank_waddr[0]),
        .wdata (bank_wdata[0]),
        .ren   (bank_ren[0]),
        .raddr (bank_raddr[0]),
        .rdata (bank_rdata[0])
    );

    feature_bank #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .DEPTH      (DEPTH),
        .DATA_WIDTH (DATA_WIDTH)
    ) u_bank1 (
        .clk   (clk),
        .wen   (bank_wen[1]),
        .waddr (bank_waddr[1]),
        .wdata (bank_wdata[1]),
        .ren   (bank_ren[1]),
        .raddr (bank_raddr[1]),
        .rdata (bank_rdata[1])
    );

    feature_bank #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .DEPTH      (DEPTH),
        .DATA_WIDTH (DATA_WIDTH)
    ) u_bank2 (
        .clk   (clk),
        .wen   (bank_wen[2]),
        .waddr (bank_waddr[2]),
        .wdata (bank_wdata[2]),
        .ren   (bank_ren[2]),
        .raddr (bank_raddr[2]),
        .rdata (bank_rdata[2])
    );

    read_return #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .DATA_WIDTH (DATA_WIDTH)
    ) u_ret (
        .clk        (clk),
        .rst_n      (rst_n),
        .axi_bank   (axi_bank),
        .sch_bank   (sch_bank),
        .axi_ren    (axi_ren),
        .axi_raddr  (axi_raddr),
        .sch_ren    (sch_ren),
        .bank_rdata (bank_rdata),
        .axi_rdata  (axi_rdata),
        .sch_rdata  (sch_rdata)
    );

endmodule

`default_nettype wire

/* verif/tb_clock_gen.sv */
// ========================================
// clock and reset for the testbench
// reset is released a tenth of a period
// after the last reset edge
// ========================================
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD       = 100,
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #(PERIOD / 10);
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

/* verif/fe_buf_tb.sv */
// ========================================
// testbench for fe_buf_top
// runs from the project root and reads
// verif/fe_buf_stimulus.txt with one op a line
// ops wait out a role change, so the model
// masks are settled before the next op
// ========================================
`default_nettype none

module fe_buf_tb
    import fe_buf_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int ADDR_WIDTH = 5;
    localparam int DEPTH      = 32;
    localparam int DATA_WIDTH = 32;
    localparam int AXI_AW     = ADDR_WIDTH + GRP_SEL_W;
    localparam int DRIVE_DLY  = 5;
    localparam int MAX_CYCLES = 2000;
    localparam int RST_WAIT   = 20;

    logic                  clk;
    logic                  rst_n;
    logic                  layer_done;
    logic                  tile_switch_r;
    stat_ctrl_t            stat_ctrl;
    logic [AXI_AW-1:0]     axi_waddr;
    logic                  axi_wen;
    logic [DATA_WIDTH-1:0] axi_wdata;
    logic [AXI_AW-1:0]     axi_raddr;
    logic                  axi_ren;
    logic [DATA_WIDTH-1:0] axi_rdata;
    grp_mask_t             pu_wen;
    logic [ADDR_WIDTH-1:0] pu_waddr;
    logic [DATA_WIDTH-1:0] pu_wdata  [ROW_GRP_NUM];
    grp_mask_t             sch_ren;
    logic [ADDR_WIDTH-1:0] sch_raddr [ROW_GRP_NUM];
    logic [DATA_WIDTH-1:0] sch_rdata [ROW_GRP_NUM];

    // reference model
    fe_state_t             m_state;
    bank_mask_t            m_axi;
    bank_mask_t            m_pu;
    bank_mask_t            m_sch;
    logic [DATA_WIDTH-1:0] shadow [BANK_NUM][ROW_GRP_NUM][DEPTH];

    logic [DATA_WIDTH-1:0] fld [10];  // operands of the current line
    logic [8*16-1:0]       tok;
    logic [8*256-1:0]      line_buf;
    int                    fd;
    int                    code;
    int                    errors;
    int                    checks;
    int                    op_no;
    int                    cycle_cnt = 0;
    bit                    timed_out;
    bit                    file_done;
    bit                    fields_ok;

    tb_clock_gen #(.PERIOD(100), .RESET_CYCLES(8)) u_clk (.clk(clk), .rst_n(rst_n));

    fe_buf_top #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .DEPTH      (DEPTH),
        .DATA_WIDTH (DATA_WIDTH)
    ) dut0 (
        .clk           (clk),
        .rst_n         (rst_n),
        .layer_done    (layer_done),
        .tile_switch_r (tile_switch_r),
        .stat_ctrl     (stat_ctrl),
        .axi_waddr     (axi_waddr),
        .axi_wen       (axi_wen),
        .axi_wdata     (axi_wdata),
        .axi_raddr     (axi_raddr),
        .axi_ren       (axi_ren),
        .axi_rdata     (axi_rdata),
        .pu_wen        (pu_wen),
        .pu_waddr      (pu_waddr),
        .pu_wdata      (pu_wdata),
        .sch_ren       (sch_ren),
        .sch_raddr     (sch_raddr),
        .sch_rdata     (sch_rdata)
    );

    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

    task automatic check_word(input string name, input logic [DATA_WIDTH-1:0] exp,
                              input logic [DATA_WIDTH-1:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_bank(input string name, input bank_mask_t exp, input bank_mask_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %s expected %b actual %b", name, exp, act);
        end
    endtask

    function automatic int bank_index(input bank_mask_t m);
        int idx;
        idx = -1;
        for (int b = 0; b < BANK_NUM; b++) begin
            if (m[b]) idx = b;
        end
        return idx;
    endfunction

    // role table on layer_done
    function automatic fe_state_t next_role(input fe_state_t s, input logic tsw);
        case (s)
            ST_S0_P1_A2: return tsw ? ST_P0_A1_S2 : ST_P0_S1_A2;
            ST_P0_S1_A2: return tsw ? ST_A0_P1_S2 : ST_S0_P1_A2;
            ST_P0_A1_S2: return tsw ? ST_A0_S1_P2 : ST_S0_A1_P2;
            ST_A0_P1_S2: return tsw ? ST_S0_A1_P2 : ST_A0_S1_P2;
            ST_S0_A1_P2: return tsw ? ST_P0_S1_A2 : ST_P0_A1_S2;
            ST_A0_S1_P2: return tsw ? ST_S0_P1_A2 : ST_A0_P1_S2;
            default:     return s;
        endcase
    endfunction

    // masks read off the state name
    task automatic set_model_masks(input fe_state_t s);
        case (s)
            ST_S0_P1_A2: {m_sch, m_pu, m_axi} = {BANK_0, BANK_1, BANK_2};
            ST_P0_S1_A2: {m_pu, m_sch, m_axi} = {BANK_0, BANK_1, BANK_2};
            ST_P0_A1_S2: {m_pu, m_axi, m_sch} = {BANK_0, BANK_1, BANK_2};
            ST_A0_P1_S2: {m_axi, m_pu, m_sch} = {BANK_0, BANK_1, BANK_2};
            ST_S0_A1_P2: {m_sch, m_axi, m_pu} = {BANK_0, BANK_1, BANK_2};
            ST_A0_S1_P2: {m_axi, m_sch, m_pu} = {BANK_0, BANK_1, BANK_2};
            default:     m_axi = BANK_0;  // pu and sch hold in ST_A0
        endcase
    endtask

    task automatic axi_write(input logic [AXI_AW-1:0] addr, input logic [DATA_WIDTH-1:0] data);
        int b;
        b = bank_index(m_axi);
        axi_waddr = addr;
        axi_wdata = data;
        axi_wen   = 1'b1;
        @(posedge clk);
        #DRIVE_DLY;
        axi_wen = 1'b0;
        if (b >= 0) shadow[b][addr[AXI_AW-1:ADDR_WIDTH]][addr[ADDR_WIDTH-1:0]] = data;
    endtask

    task automatic axi_read(input logic [AXI_AW-1:0] addr, input logic [DATA_WIDTH-1:0] exp,
                            input string name);
        int b;
        b = bank_index(m_axi);
        axi_raddr = addr;
        axi_ren   = 1'b1;
        @(posedge clk);
        #DRIVE_DLY;
        axi_ren = 1'b0;
        check_word({name, " file"}, exp, axi_rdata);
        if (b >= 0) begin
            check_word({name, " model"}, shadow[b][addr[AXI_AW-1:ADDR_WIDTH]][addr[ADDR_WIDTH-1:0]],
                       axi_rdata);
        end
    endtask

    // words come from fld[2..5]
    task automatic pu_write(input grp_mask_t wen, input logic [ADDR_WIDTH-1:0] row);
        int b;
        b = bank_index(m_pu);
        pu_wen   = wen;
        pu_waddr = row;
        for (int g = 0; g < ROW_GRP_NUM; g++) pu_wdata[g] = fld[2+g];
        @(posedge clk);
        #DRIVE_DLY;
        pu_wen = '0;
        for (int g = 0; g < ROW_GRP_NUM; g++) begin
            if (b >= 0 && wen[g]) shadow[b][g][row] = fld[2+g];
        end
    endtask

    // rows in fld[1..4] and expected words in fld[5..8]
    task automatic sch_read(input grp_mask_t ren);
        int    b;
        string name;
        b = bank_index(m_sch);
        sch_ren = ren;
        for (int g = 0; g < ROW_GRP_NUM; g++) sch_raddr[g] = fld[1+g][ADDR_WIDTH-1:0];
        @(posedge clk);
        #DRIVE_DLY;
        sch_ren = '0;
        for (int g = 0; g < ROW_GRP_NUM; g++) begin
            if (ren[g]) begin
                name = $sformatf("op%0d sch_rd grp%0d row%0d", op_no, g, fld[1+g]);
                check_word({name, " file"}, fld[5+g], sch_rdata[g]);
                if (b >= 0) begin
                    check_word({name, " model"}, shadow[b][g][fld[1+g][ADDR_WIDTH-1:0]],
                               sch_rdata[g]);
                end
            end
        end
    endtask

    // strobe edge and one more edge for the registered masks
    task automatic role_change(input bit is_start, input logic tsw, input bank_mask_t exp_axi,
                               input bank_mask_t exp_pu, input bank_mask_t exp_sch);
        string name;
        name = $sformatf("op%0d %s", op_no, is_start ? "start" : "layer_done");
        if (is_start) begin
            stat_ctrl = STAT_START;
        end else begin
            layer_done    = 1'b1;
            tile_switch_r = tsw;
        end
        @(posedge clk);
        #DRIVE_DLY;
        stat_ctrl     = STAT_IDLE;
        layer_done    = 1'b0;
        tile_switch_r = 1'b0;
        // masks still show the old roles here
        check_bank({name, " axi hold"}, m_axi, dut0.axi_bank);
        check_bank({name, " pu hold"}, m_pu, dut0.pu_bank);
        check_bank({name, " sch hold"}, m_sch, dut0.sch_bank);
        if (is_start) begin
            if (m_state == ST_A0) m_state = ST_S0_P1_A2;
        end else begin
            m_state = next_role(m_state, tsw);
        end
        set_model_masks(m_state);
        @(posedge clk);
        #DRIVE_DLY;
        check_bank({name, " axi model"}, exp_axi, m_axi);
        check_bank({name, " pu model"}, exp_pu, m_pu);
        check_bank({name, " sch model"}, exp_sch, m_sch);
        check_bank({name, " axi dut"}, exp_axi, dut0.axi_bank);
        check_bank({name, " pu dut"}, exp_pu, dut0.pu_bank);
        check_bank({name, " sch dut"}, exp_sch, dut0.sch_bank);
    endtask

    task automatic read_fields(input int n);
        fields_ok = 1'b1;
        for (int i = 0; i < n; i++) begin
            code = $fscanf(fd, "%h", fld[i]);
            if (code != 1) fields_ok = 1'b0;
        end
        if (!fields_ok) begin
            errors++;
            $display("stimulus op %0d is missing operands", op_no);
        end
    endtask

    task automatic run_op();
        if (tok == "#") begin
            code = $fgets(line_buf, fd);  // comment line
        end else begin
            op_no++;
            if (tok == "axi_wr") begin
                read_fields(2);
                if (fields_ok) axi_write(fld[0][AXI_AW-1:0], fld[1]);
            end else if (tok == "axi_rd") begin
                read_fields(2);
                if (fields_ok) axi_read(fld[0][AXI_AW-1:0], fld[1],
                                        $sformatf("op%0d axi_rd %h", op_no, fld[0]));
            end else if (tok == "pu_wr") begin
                read_fields(6);
                if (fields_ok) pu_write(fld[0][ROW_GRP_NUM-1:0], fld[1][ADDR_WIDTH-1:0]);
            end else if (tok == "sch_rd") begin
                read_fields(9);
                if (fields_ok) sch_read(fld[0][ROW_GRP_NUM-1:0]);
            end else if (tok == "start") begin
                read_fields(3);
                if (fields_ok) role_change(1'b1, 1'b0, fld[0][2:0], fld[1][2:0], fld[2][2:0]);
            end else if (tok == "done") begin
                read_fields(4);
                if (fields_ok) role_change(1'b0, fld[0][0], fld[1][2:0], fld[2][2:0], fld[3][2:0]);
            end else if (tok == "idle") begin
                read_fields(1);
                for (int i = 0; fields_ok && i < fld[0] && cycle_cnt <= MAX_CYCLES; i++) begin
                    @(posedge clk);
                    #DRIVE_DLY;
                end
            end else begin
                errors++;
                $display("unknown operation %0s at stimulus op %0d", tok, op_no);
            end
        end
    endtask

    initial begin
        int n;
        layer_done    = 1'b0;
        tile_switch_r = 1'b0;
        stat_ctrl     = STAT_IDLE;
        axi_waddr     = '0;
        axi_wen       = 1'b0;
        axi_wdata     = '0;
        axi_raddr     = '0;
        axi_ren       = 1'b0;
        pu_wen        = '0;
        pu_waddr      = '0;
        sch_ren       = '0;
        for (int g = 0; g < ROW_GRP_NUM; g++) begin
            pu_wdata[g]  = '0;
            sch_raddr[g] = '0;
        end
        errors    = 0;
        checks    = 0;
        op_no     = 0;
        timed_out = 1'b0;
        file_done = 1'b0;
        m_state   = ST_A0;
        m_axi     = BANK_NONE;
        m_pu      = BANK_NONE;
        m_sch     = BANK_NONE;

        n = 0;
        while (rst_n !== 1'b1 && n < RST_WAIT) begin
            @(posedge clk);
            n++;
        end
        if (rst_n !== 1'b1) begin
            timed_out = 1'b1;
            $display("timeout: reset was not released within %0d cycles", RST_WAIT);
        end else begin
            @(posedge clk);
            #DRIVE_DLY;
            m_axi = BANK_0;  // AXI owns bank0 one cycle after reset
            fd = $fopen("verif/fe_buf_stimulus.txt", "r");
            if (fd == 0) begin
                errors++;
                $display("could not open verif/fe_buf_stimulus.txt");
            end else begin
                while (!file_done && !timed_out) begin
                    if (cycle_cnt > MAX_CYCLES) begin
                        timed_out = 1'b1;
                        $display("timeout: stimulus file not finished in %0d cycles", MAX_CYCLES);
                    end else begin
                        code = $fscanf(fd, "%s", tok);
                        if (code != 1) file_done = 1'b1;
                        else run_op();
                    end
                end
                $fclose(fd);
            end
        end

        $display("ops %0d, checks %0d, errors %0d, timeouts %0d", op_no, checks, errors, timed_out);
        if (errors == 0 && !timed_out) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verif/fe_buf_stimulus.txt */
# axi_wr addr data | axi_rd addr exp | pu_wr wen row d0 d1 d2 d3 | idle cycles
# sch_rd ren r0 r1 r2 r3 e0 e1 e2 e3 | start axi pu sch | done tsw axi pu sch (hex)
axi_wr 02 a0000002
axi_rd 02 a0000002
axi_wr 22 a1000002
axi_rd 22 a1000002
axi_wr 42 a2000002
axi_rd 42 a2000002
axi_wr 62 a3000002
axi_rd 62 a3000002
axi_rd 22 a1000002
axi_wr 07 a0000007
axi_wr 4b a200000b
start 4 2 1
axi_wr 47 c2000047
axi_rd 47 c2000047
pu_wr f 04 b0000004 b1000004 b2000004 b3000004
pu_wr 5 04 d0000004 d1000004 d2000004 d3000004
sch_rd f 02 02 02 02 a0000002 a1000002 a2000002 a3000002
sch_rd 1 07 00 00 00 a0000007 00000000 00000000 00000000
done 0 4 1 2
sch_rd f 04 04 04 04 d0000004 b1000004 d2000004 b3000004
axi_rd 47 c2000047
pu_wr 6 02 e0000002 e1000002 e2000002 e3000002
done 1 1 2 4
axi_rd 22 e1000002
axi_rd 62 a3000002
axi_wr 69 f3000009
axi_rd 69 f3000009
done 1 2 4 1
axi_rd 04 d0000004
axi_rd 24 b1000004
sch_rd f 07 02 0b 09 a0000007 e1000002 a200000b f3000009
done 1 4 1 2
axi_rd 47 c2000047
idle 2

/* src.f */
logic/fe_buf_pkg.sv
logic/bank_role_fsm.sv
logic/bank_port_mux.sv
logic/feature_bank.sv
logic/read_return.sv
logic/fe_buf_top.sv
verif/tb_clock_gen.sv
verif/fe_buf_tb.sv
